// ==== source/apbTypes.sv ====
//**********************************************************************
// Shared types for the approximate-begin branch buffer.
// Index is address bits 7:2 and tag is bits 17:8, so addresses are
// assumed word aligned. The bank is the low bits of the index.
//**********************************************************************

package apbTypes;

    typedef logic [31:0] pcT;

    localparam int insnBytes = 4;

    // Table geometry
    localparam int entryNum = 64;
    localparam int indexBits = $clog2(entryNum);
    localparam int idxLsb = 2;
    localparam int bankNum = 4;
    localparam int bankBits = $clog2(bankNum);
    localparam int rowNum = entryNum / bankNum;

    typedef logic [indexBits-1:0] indexT;
    typedef logic [bankBits-1:0] bankT;
    typedef logic [indexBits-bankBits-1:0] rowT;

    // Tag sits right above the index
    localparam int tagBits = 10;
    localparam int tagLsb = idxLsb + indexBits;

    typedef logic [tagBits-1:0] tagT;

    typedef struct packed {
        logic valid;
        tagT  tag;
    } bufferEntryT;

    typedef struct packed {
        logic valid;
        logic isApproxBegin;
        pcT   brAddr;
    } branchResultT;

    typedef struct packed {
        logic        en;
        indexT       idx;
        bufferEntryT entry;
    } writeReqT;

    typedef enum logic {
        stSweep,
        stReady
    } sweepStateT;

    function automatic indexT toIndex(pcT addr);
        return addr[idxLsb +: indexBits];
    endfunction

    function automatic tagT toTag(pcT addr);
        return addr[tagLsb +: tagBits];
    endfunction

    function automatic bankT toBank(indexT idx);
        return idx[bankBits-1:0];
    endfunction

    function automatic rowT toRow(indexT idx);
        return idx[indexBits-1:bankBits];
    endfunction

endpackage

// ==== source/bankedTagRam.sv ====
//**********************************************************************
// Banked tag table with registered read data, one cycle latency.
// At most one enabled write per bank per cycle is expected; the
// table does no arbitration. No reset on the storage.
//**********************************************************************

`timescale 1ns/100ps

module bankedTagRam #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2
) (
    input  logic                  clk,
    input  apbTypes::indexT       rdIdx   [fetchWidth],
    output apbTypes::bufferEntryT rdEntry [fetchWidth],
    input  apbTypes::writeReqT    wrReq   [issueWidth]
);

    import apbTypes::*;

    // Storage organised as bank by row
    bufferEntryT bankMem [bankNum][rowNum];

    always_ff @(posedge clk) begin
        for (int p = 0; p < issueWidth; p++) begin
            if (wrReq[p].en) begin
                bankMem[toBank(wrReq[p].idx)][toRow(wrReq[p].idx)] <= wrReq[p].entry;
            end
        end
    end

    // Read returns the value from before this edge's writes
    always_ff @(posedge clk) begin
        for (int i = 0; i < fetchWidth; i++) begin
            rdEntry[i] <= bankMem[toBank(rdIdx[i])][toRow(rdIdx[i])];
        end
    end

endmodule

// ==== source/conflictQueue.sv ====
//**********************************************************************
// FIFO for bank-conflicted writes. Push and pop may share a cycle.
// A push while full is ignored, even if a pop happens that cycle.
// headData is only meaningful while empty is low.
//**********************************************************************

`timescale 1ns/100ps

module conflictQueue #(
    parameter int queueDepth = 4
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               push,
    input  logic               pop,
    input  apbTypes::writeReqT pushData,
    output apbTypes::writeReqT headData,
    output logic               full,
    output logic               empty
);

    import apbTypes::*;

    localparam int ptrBits = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int cntBits = $clog2(queueDepth + 1);

    typedef logic [ptrBits-1:0] ptrT;
    typedef logic [cntBits-1:0] cntT;

    writeReqT slots [queueDepth];
    ptrT      headPtr;
    ptrT      tailPtr;
    cntT      count;
    logic     doPush;
    logic     doPop;

    // Wrap explicitly so non power of two depths work
    function automatic ptrT nextPtr(ptrT p);
        return (p == ptrT'(queueDepth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign doPush = push && !full;
    assign doPop = pop && !empty;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (doPop) begin
                headPtr <= nextPtr(headPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            slots[tailPtr] <= pushData;
        end
    end

    assign headData = slots[headPtr];
    assign full = (count == cntT'(queueDepth));
    assign empty = (count == '0);

endmodule

// ==== source/writeArbiter.sv ====
//**********************************************************************
// Write port arbitration and the post-reset clearing sweep.
// Only the first bank conflict per cycle is queued; any further
// conflicting request in the same cycle is dropped (wide issue only).
// Branch results are ignored until ready is high.
//**********************************************************************

`timescale 1ns/100ps

module writeArbiter #(
    parameter int issueWidth = 2
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  apbTypes::branchResultT brResult [issueWidth],
    input  apbTypes::writeReqT     headData,
    input  logic                   full,
    input  logic                   empty,
    output logic                   push,
    output logic                   pop,
    output apbTypes::writeReqT     pushData,
    output apbTypes::writeReqT     wrReq    [issueWidth],
    output logic                   ready
);

    import apbTypes::*;

    sweepStateT state;
    indexT      sweepIdx;
    logic       demoted;
    logic       headBlocked;
    logic       headPlaced;

    // Sweep one entry per cycle, then stay ready
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stSweep;
            sweepIdx <= '0;
        end else if (state == stSweep) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (sweepIdx == indexT'(entryNum - 1)) begin
                state <= stReady;
            end
        end
    end

    always_comb begin
        push = 1'b0;
        pop = 1'b0;
        pushData = '0;
        demoted = 1'b0;
        headBlocked = 1'b0;
        headPlaced = 1'b0;

        // Qualifying results become direct writes
        for (int i = 0; i < issueWidth; i++) begin
            wrReq[i].en = brResult[i].valid && brResult[i].isApproxBegin;
            wrReq[i].idx = toIndex(brResult[i].brAddr);
            wrReq[i].entry.valid = 1'b1;
            wrReq[i].entry.tag = toTag(brResult[i].brAddr);
        end

        // Lower port wins the bank; loser goes to the queue
        for (int i = 1; i < issueWidth; i++) begin
            for (int j = 0; j < i; j++) begin
                if (wrReq[i].en && wrReq[j].en &&
                    toBank(wrReq[i].idx) == toBank(wrReq[j].idx)) begin
                    if (!demoted) begin
                        push = !full;
                        pushData = wrReq[i];
                        // Queue entries carry no enable
                        pushData.en = 1'b0;
                    end
                    demoted = 1'b1;
                    wrReq[i].en = 1'b0;
                end
            end
        end

        // Drain head onto the lowest idle port if its bank is free
        if (!empty) begin
            for (int j = 0; j < issueWidth; j++) begin
                if (wrReq[j].en && toBank(wrReq[j].idx) == toBank(headData.idx)) begin
                    headBlocked = 1'b1;
                end
            end
            for (int i = 0; i < issueWidth; i++) begin
                if (!headBlocked && !headPlaced && !wrReq[i].en) begin
                    wrReq[i] = headData;
                    wrReq[i].en = 1'b1;
                    headPlaced = 1'b1;
                end
            end
            pop = headPlaced;
        end

        // Sweep owns port 0 and silences everything else
        if (state == stSweep) begin
            for (int i = 0; i < issueWidth; i++) begin
                wrReq[i] = '0;
            end
            wrReq[0].en = 1'b1;
            wrReq[0].idx = sweepIdx;
            push = 1'b0;
            pop = 1'b0;
        end
    end

    assign ready = (state == stReady);

endmodule

// ==== source/fetchLookup.sv ====
//**********************************************************************
// Per-slot lookup. Slot i uses predNextPc + i * insnBytes.
// Hit appears one cycle after the address; lookups issued before
// ready are reported as misses.
//**********************************************************************

`timescale 1ns/100ps

module fetchLookup #(
    parameter int fetchWidth = 2
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  ready,
    input  apbTypes::pcT          predNextPc,
    output apbTypes::indexT       rdIdx     [fetchWidth],
    input  apbTypes::bufferEntryT rdEntry   [fetchWidth],
    output logic [fetchWidth-1:0] bufferHit
);

    import apbTypes::*;

    pcT   slotPc [fetchWidth];
    tagT  tagReg [fetchWidth];
    logic lookupOk;

    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            slotPc[i] = predNextPc + pcT'(i * insnBytes);
            rdIdx[i] = toIndex(slotPc[i]);
        end
    end

    // Tag and ready travel alongside the table read
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lookupOk <= 1'b0;
            tagReg <= '{default: '0};
        end else begin
            lookupOk <= ready;
            for (int i = 0; i < fetchWidth; i++) begin
                tagReg[i] <= toTag(slotPc[i]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            bufferHit[i] = lookupOk && rdEntry[i].valid && (rdEntry[i].tag == tagReg[i]);
        end
    end

endmodule

// ==== source/approxBranchBuffer.sv ====
//**********************************************************************
// Approximate-begin branch buffer, hit/miss only, no targets stored.
// Requests are single-cycle with no handshake. Conflict queue
// overflow silently drops the write.
//**********************************************************************

`timescale 1ns/100ps

module approxBranchBuffer #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2,
    parameter int queueDepth = 4
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  apbTypes::pcT           predNextPc,
    input  apbTypes::branchResultT brResult  [issueWidth],
    output logic [fetchWidth-1:0]  bufferHit,
    output logic                   ready
);

    import apbTypes::*;

    indexT       rdIdx   [fetchWidth];
    bufferEntryT rdEntry [fetchWidth];
    writeReqT    wrReq   [issueWidth];
    writeReqT    pushData;
    writeReqT    headData;
    logic        push;
    logic        pop;
    logic        full;
    logic        empty;

    fetchLookup #(
        .fetchWidth(fetchWidth)
    ) lookup (
        .clk       (clk),
        .arstN     (arstN),
        .ready     (ready),
        .predNextPc(predNextPc),
        .rdIdx     (rdIdx),
        .rdEntry   (rdEntry),
        .bufferHit (bufferHit)
    );

    writeArbiter #(
        .issueWidth(issueWidth)
    ) arbiter (
        .clk     (clk),
        .arstN   (arstN),
        .brResult(brResult),
        .headData(headData),
        .full    (full),
        .empty   (empty),
        .push    (push),
        .pop     (pop),
        .pushData(pushData),
        .wrReq   (wrReq),
        .ready   (ready)
    );

    conflictQueue #(
        .queueDepth(queueDepth)
    ) queue (
        .clk     (clk),
        .arstN   (arstN),
        .push    (push),
        .pop     (pop),
        .pushData(pushData),
        .headData(headData),
        .full    (full),
        .empty   (empty)
    );

    bankedTagRam #(
        .fetchWidth(fetchWidth),
        .issueWidth(issueWidth)
    ) table0 (
        .clk    (clk),
        .rdIdx  (rdIdx),
        .rdEntry(rdEntry),
        .wrReq  (wrReq)
    );

endmodule

// ==== verif/tbApproxBuffer.sv ====
//**********************************************************************
// Testbench for approxBranchBuffer with fetchWidth and issueWidth of 2.
// Expected hits come from the directed table or from a small model of
// index and tag. Random gaps must be long enough for the queue to drain.
//**********************************************************************

`timescale 1ns/100ps

module tbApproxBuffer;

    import apbTypes::*;

    localparam int clkPeriod = 8;
    localparam int numDirected = 11;
    localparam int numRandom = 24;
    localparam int randIdle = 4;
    localparam pcT noAddr = 32'h0;

    // One directed test: two write ports, a gap, one lookup
    typedef struct packed {
        pcT         addr0;
        logic [1:0] flag0;
        pcT         addr1;
        logic [1:0] flag1;
        logic [3:0] idle;
        pcT         lookup;
        logic [1:0] expHit;
    } stimT;

    // Flags are {valid, isApproxBegin}
    localparam stimT directed [numDirected] = '{
        '{noAddr, 2'b00, noAddr, 2'b00, 4'd0, 32'h0000_1240, 2'b00},
        '{32'h0000_1240, 2'b11, noAddr, 2'b00, 4'd0, 32'h0000_1240, 2'b01},
        '{noAddr, 2'b00, noAddr, 2'b00, 4'd0, 32'h0000_123C, 2'b10},
        '{32'h0000_2384, 2'b10, noAddr, 2'b00, 4'd0, 32'h0000_2384, 2'b00},
        '{32'h0000_2384, 2'b01, noAddr, 2'b00, 4'd0, 32'h0000_2384, 2'b00},
        '{noAddr, 2'b00, noAddr, 2'b00, 4'd0, 32'h0000_5640, 2'b00},
        '{32'h0000_5640, 2'b11, noAddr, 2'b00, 4'd0, 32'h0000_5640, 2'b01},
        '{noAddr, 2'b00, noAddr, 2'b00, 4'd0, 32'h0000_1240, 2'b00},
        '{32'h0000_3110, 2'b11, 32'h0000_3114, 2'b11, 4'd0, 32'h0000_3110, 2'b11},
        '{32'h0000_4420, 2'b11, 32'h0000_4460, 2'b11, 4'd6, 32'h0000_4420, 2'b01},
        '{noAddr, 2'b00, noAddr, 2'b00, 4'd0, 32'h0000_4460, 2'b01}
    };

    string testNames [numDirected] = '{
        "emptyMiss", "singleWrite", "slot1Hit", "notApprox", "notValid", "tagMiss",
        "tagReplace", "oldTagGone", "twoBanks", "sameBank", "sameBankLate"
    };

    logic         clk;
    logic         arstN;
    pcT           predNextPc;
    branchResultT brResult [2];
    logic [1:0]   bufferHit;
    logic         ready;

    logic         modelValid [entryNum];
    logic [9:0]   modelTag   [entryNum];
    logic [31:0]  lfsrState = 32'h977e0887;
    int           passCount = 0;
    int           failCount = 0;

    approxBranchBuffer #(
        .fetchWidth(2),
        .issueWidth(2),
        .queueDepth(4)
    ) uut (
        .clk       (clk),
        .arstN     (arstN),
        .predNextPc(predNextPc),
        .brResult  (brResult),
        .bufferHit (bufferHit),
        .ready     (ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Galois form stepped once per bit
    function automatic logic lfsrBit();
        logic lsb;
        lsb = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (lsb) begin
            lfsrState = lfsrState ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsrBit()};
        end
        return r;
    endfunction

    // Small tag range so random lookups revisit written entries
    function automatic pcT randAddr();
        logic [31:0] r;
        r = randBits(8);
        return {22'b0, r[7:6], r[5:0], 2'b00};
    endfunction

    function automatic void recordWrite(pcT a, logic [1:0] flags);
        if (flags == 2'b11) begin
            modelValid[a[7:2]] = 1'b1;
            modelTag[a[7:2]] = a[17:8];
        end
    endfunction

    function automatic logic [1:0] expectHits(pcT base);
        logic [1:0] hits;
        pcT         a;
        for (int i = 0; i < 2; i++) begin
            a = base + pcT'(i * 4);
            hits[i] = modelValid[a[7:2]] && (modelTag[a[7:2]] == a[17:8]);
        end
        return hits;
    endfunction

    task automatic report(string name, logic [31:0] expected, logic [31:0] actual);
        logic ok;
        ok = (expected === actual);
        assert (ok) else begin
            $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
        end
        if (ok) begin
            $display("[PASS] %s value %0d", name, actual);
            passCount++;
        end else begin
            failCount++;
        end
    endtask

    task automatic runTest(string name, stimT t, logic [1:0] exp);
        @(posedge clk);
        brResult[0] <= {t.flag0, t.addr0};
        brResult[1] <= {t.flag1, t.addr1};
        @(posedge clk);
        brResult[0] <= '0;
        brResult[1] <= '0;
        repeat (t.idle) @(posedge clk);
        predNextPc <= t.lookup;
        @(posedge clk);
        @(negedge clk);
        report(name, 32'(exp), 32'(bufferHit));
    endtask

    initial begin
        int   riseCycle;
        stimT t;
        logic [31:0] pick;
        arstN = 1'b0;
        predNextPc = '0;
        brResult = '{default: '0};
        for (int i = 0; i < entryNum; i++) begin
            modelValid[i] = 1'b0;
            modelTag[i] = '0;
        end
        repeat (4) @(posedge clk);
        arstN <= 1'b1;

        // Sweep length counted from the first edge out of reset
        riseCycle = 0;
        for (int c = 1; c <= entryNum + 8 && riseCycle == 0; c++) begin
            @(posedge clk);
            @(negedge clk);
            if (ready) begin
                riseCycle = c;
            end
        end
        report("resetSweep", 32'(entryNum), 32'(riseCycle));

        for (int n = 0; n < numDirected; n++) begin
            recordWrite(directed[n].addr0, directed[n].flag0);
            recordWrite(directed[n].addr1, directed[n].flag1);
            runTest(testNames[n], directed[n], directed[n].expHit);
        end

        for (int n = 0; n < numRandom; n++) begin
            pick = randBits(3);
            t.addr0 = randAddr();
            t.flag0 = {1'b1, pick[0]};
            t.addr1 = randAddr();
            t.flag1 = {1'b1, pick[1]};
            t.idle = 4'(randIdle);
            t.lookup = pick[2] ? t.addr0 : randAddr();
            t.expHit = 2'b00;
            recordWrite(t.addr0, t.flag0);
            recordWrite(t.addr1, t.flag1);
            runTest($sformatf("random%0d", n), t, expectHits(t.lookup));
        end

        $display("Tests run %0d, passed %0d, failed %0d",
                 passCount + failCount, passCount, failCount);
        if (failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Bound from the longest test length, plus the sweep and reset
    initial begin
        int maxIdle;
        int limit;
        maxIdle = randIdle;
        for (int n = 0; n < numDirected; n++) begin
            if (int'(directed[n].idle) > maxIdle) begin
                maxIdle = int'(directed[n].idle);
            end
        end
        limit = (numDirected + numRandom) * (maxIdle + 4) + 2 * entryNum + 16;
        #(limit * clkPeriod);
        $display("Watchdog expired after %0d cycles before the tests finished", limit);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
source/apbTypes.sv
source/bankedTagRam.sv
source/conflictQueue.sv
source/writeArbiter.sv
source/fetchLookup.sv
source/approxBranchBuffer.sv
verif/tbApproxBuffer.sv

// ==== Makefile ====
# Verilator build and run for the approximate-begin branch buffer

VERILATOR ?= verilator
TOP       ?= tbApproxBuffer
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Fails unless the pass message appears in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
